/* logic/noc_defines.svh */
////////////////////
// Sizes shared by the mesh, the tiles and the flit types
// Include wherever a width or the mesh size is needed
////////////////////

`ifndef NOC_DEFINES_SVH
`define NOC_DEFINES_SVH

// Mesh dimensions
`define NOC_MESH_X 2
`define NOC_MESH_Y 2

// Command tag, up to 8 outstanding
`define NOC_TAG_W 3

// Data word and memory size per tile
`define NOC_DATA_W 32
`define NOC_MEM_WORDS 16

`endif

/* logic/noc_pkg.sv */
////////////////////
// Types for the request and response planes of the mesh
// Referenced by scoped name from the router and the tiles
////////////////////

`include "noc_defines.svh"

package noc_pkg;

   // Router port numbering, mesh links use 1 to 4
   typedef enum logic [2:0] {
      DIR_LOCAL = 3'd0,
      DIR_NORTH = 3'd1,
      DIR_EAST  = 3'd2,
      DIR_SOUTH = 3'd3,
      DIR_WEST  = 3'd4
   } route_dir_e;

   typedef enum logic {
      MEM_READ  = 1'b0,
      MEM_WRITE = 1'b1
   } mem_op_e;

   typedef struct packed {
      logic x;
      logic y;
   } coord_t;

   // Destination must stay in the low bits of both flits
   typedef struct packed {
      logic [`NOC_DATA_W-1:0]            data;
      logic [$clog2(`NOC_MEM_WORDS)-1:0] addr;
      mem_op_e                           op;
      logic [`NOC_TAG_W-1:0]             tag;
      coord_t                            src;
      coord_t                            dst;
   } req_flit_t;

   typedef struct packed {
      logic [`NOC_DATA_W-1:0] data;
      logic [`NOC_TAG_W-1:0]  tag;
      coord_t                 dst;
   } rsp_flit_t;

endpackage

/* logic/noc_router.sv */
////////////////////
// Five-port XY router with one-entry input buffers
// Serves either plane, the destination sits in the flit's low bits
////////////////////

`timescale 1ns/1ps

module noc_router #(
   parameter int FLIT_W  = 8,
   parameter int X_COORD = 0,
   parameter int Y_COORD = 0
) (
   input  logic                   clk_i,
   input  logic                   reset_i,
   input  logic [4:0]             in_valid_i,
   input  logic [4:0][FLIT_W-1:0] in_flit_i,
   output logic [4:0]             in_stall_o,
   output logic [4:0]             out_valid_o,
   output logic [4:0][FLIT_W-1:0] out_flit_o,
   input  logic [4:0]             out_stall_i
);

   logic [4:0]             buf_valid_q;
   logic [4:0][FLIT_W-1:0] buf_flit_q;
   logic [4:0]             cand_valid;
   logic [4:0][FLIT_W-1:0] cand_flit;
   noc_pkg::route_dir_e    route [5];

   logic [4:0]             out_valid_q;
   logic [4:0][FLIT_W-1:0] out_flit_q;
   logic [4:0]             out_free;
   logic [4:0]             out_load;
   logic [4:0][2:0]        out_sel;
   logic [4:0][2:0]        rr_q;
   logic [4:0]             in_grant;

   // Empty buffer lets the arriving flit straight through
   assign cand_valid = buf_valid_q | in_valid_i;
   assign out_free   = ~out_valid_q | ~out_stall_i;

   assign in_stall_o  = buf_valid_q;
   assign out_valid_o = out_valid_q;
   assign out_flit_o  = out_flit_q;

   ////////////////////
   // Route compute
   ////////////////////

   always_comb begin
      noc_pkg::coord_t dst;
      for (int i = 0; i < 5; i++) begin
         cand_flit[i] = buf_valid_q[i] ? buf_flit_q[i] : in_flit_i[i];
         dst = cand_flit[i][$bits(noc_pkg::coord_t)-1:0];
         // X first, then Y
         if (int'(dst.x) > X_COORD) begin
            route[i] = noc_pkg::DIR_EAST;
         end else if (int'(dst.x) < X_COORD) begin
            route[i] = noc_pkg::DIR_WEST;
         end else if (int'(dst.y) > Y_COORD) begin
            route[i] = noc_pkg::DIR_NORTH;
         end else if (int'(dst.y) < Y_COORD) begin
            route[i] = noc_pkg::DIR_SOUTH;
         end else begin
            route[i] = noc_pkg::DIR_LOCAL;
         end
      end
   end

   ////////////////////
   // Round-robin arbiters
   ////////////////////

   always_comb begin
      int idx;
      out_load = '0;
      out_sel  = '0;
      in_grant = '0;
      for (int o = 0; o < 5; o++) begin
         // Lowest offset from the pointer wins, so scan it last
         for (int k = 4; k >= 0; k--) begin
            idx = (int'(rr_q[o]) + k) % 5;
            if (cand_valid[idx] && int'(route[idx]) == o && out_free[o]) begin
               out_load[o] = 1'b1;
               out_sel[o]  = 3'(idx);
            end
         end
         if (out_load[o]) begin
            in_grant[out_sel[o]] = 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         buf_valid_q <= '0;
         out_valid_q <= '0;
         rr_q        <= '0;
      end else begin
         for (int i = 0; i < 5; i++) begin
            if (buf_valid_q[i]) begin
               if (in_grant[i]) begin
                  buf_valid_q[i] <= 1'b0;
               end
            end else if (in_valid_i[i] && !in_grant[i]) begin
               buf_valid_q[i] <= 1'b1;
            end
         end
         for (int o = 0; o < 5; o++) begin
            if (out_load[o]) begin
               out_valid_q[o] <= 1'b1;
               rr_q[o]        <= (out_sel[o] == 3'd4) ? 3'd0 : out_sel[o] + 3'd1;
            end else if (!out_stall_i[o]) begin
               out_valid_q[o] <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      for (int i = 0; i < 5; i++) begin
         if (!buf_valid_q[i]) begin
            buf_flit_q[i] <= in_flit_i[i];
         end
      end
      for (int o = 0; o < 5; o++) begin
         if (out_load[o]) begin
            out_flit_q[o] <= cand_flit[out_sel[o]];
         end
      end
   end

   for (genvar g = 0; g < 5; g++) begin : gen_chk
      a_out_hold : assert property (@(posedge clk_i) disable iff (reset_i)
         out_valid_q[g] && out_stall_i[g] |=> out_valid_q[g] && $stable(out_flit_q[g]))
         else $error("router (%0d,%0d) output %0d changed under stall", X_COORD, Y_COORD, g);

      // Neighbors must never address a flit back the way it came
      a_no_uturn : assert property (@(posedge clk_i) disable iff (reset_i)
         cand_valid[g] |-> int'(route[g]) != g)
         else $error("router (%0d,%0d) flit turned back on port %0d", X_COORD, Y_COORD, g);
   end

endmodule

/* logic/host_tile.sv */
////////////////////
// Host tile at (0,0)
// Packs external commands into request flits and returns responses by tag
////////////////////

`timescale 1ns/1ps

`include "noc_defines.svh"

module host_tile (
   input  logic                              clk_i,
   input  logic                              reset_i,
   input  logic                              cmd_valid_i,
   input  noc_pkg::mem_op_e                  cmd_op_i,
   input  noc_pkg::coord_t                   cmd_tile_i,
   input  logic [$clog2(`NOC_MEM_WORDS)-1:0] cmd_addr_i,
   input  logic [`NOC_DATA_W-1:0]            cmd_data_i,
   input  logic [`NOC_TAG_W-1:0]             cmd_tag_i,
   output logic                              cmd_busy_o,
   output logic                              rsp_valid_o,
   output logic [`NOC_TAG_W-1:0]             rsp_tag_o,
   output logic [`NOC_DATA_W-1:0]            rsp_data_o,
   output logic [4:1]                        req_out_valid_o,
   output noc_pkg::req_flit_t [4:1]          req_out_flit_o,
   input  logic [4:1]                        req_out_stall_i,
   input  logic [4:1]                        req_in_valid_i,
   input  noc_pkg::req_flit_t [4:1]          req_in_flit_i,
   output logic [4:1]                        req_in_stall_o,
   output logic [4:1]                        rsp_out_valid_o,
   output noc_pkg::rsp_flit_t [4:1]          rsp_out_flit_o,
   input  logic [4:1]                        rsp_out_stall_i,
   input  logic [4:1]                        rsp_in_valid_i,
   input  noc_pkg::rsp_flit_t [4:1]          rsp_in_flit_i,
   output logic [4:1]                        rsp_in_stall_o
);

   localparam int NumTags = 1 << `NOC_TAG_W;

   logic                 cmd_take;
   logic                 inj_valid_q;
   noc_pkg::req_flit_t   inj_flit_q;
   logic                 inj_stall;
   logic [NumTags-1:0]   tag_busy_q;
   logic [NumTags-1:0]   tag_set;
   logic [NumTags-1:0]   tag_clr;
   logic                 req_loc_valid;
   noc_pkg::req_flit_t   req_loc_flit;
   logic                 rsp_loc_stall;
   noc_pkg::rsp_flit_t   rsp_loc_flit;

   assign cmd_busy_o = (inj_valid_q && inj_stall) || (&tag_busy_q);
   assign cmd_take   = cmd_valid_i && !cmd_busy_o;

   assign rsp_tag_o  = rsp_loc_flit.tag;
   assign rsp_data_o = rsp_loc_flit.data;

   assign tag_set = cmd_take ? NumTags'(1) << cmd_tag_i : '0;
   assign tag_clr = rsp_valid_o ? NumTags'(1) << rsp_tag_o : '0;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         inj_valid_q <= 1'b0;
         tag_busy_q  <= '0;
      end else begin
         if (cmd_take) begin
            inj_valid_q <= 1'b1;
         end else if (!inj_stall) begin
            inj_valid_q <= 1'b0;
         end
         tag_busy_q <= (tag_busy_q | tag_set) & ~tag_clr;
      end
   end

   always_ff @(posedge clk_i) begin
      if (cmd_take) begin
         inj_flit_q.data <= cmd_data_i;
         inj_flit_q.addr <= cmd_addr_i;
         inj_flit_q.op   <= cmd_op_i;
         inj_flit_q.tag  <= cmd_tag_i;
         inj_flit_q.src  <= '0;
         inj_flit_q.dst  <= cmd_tile_i;
      end
   end

   noc_router #(
      .FLIT_W ($bits(noc_pkg::req_flit_t)),
      .X_COORD(0),
      .Y_COORD(0)
   ) i_req_router (
      .clk_i,
      .reset_i,
      .in_valid_i ({req_in_valid_i, inj_valid_q}),
      .in_flit_i  ({req_in_flit_i, inj_flit_q}),
      .in_stall_o ({req_in_stall_o, inj_stall}),
      .out_valid_o({req_out_valid_o, req_loc_valid}),
      .out_flit_o ({req_out_flit_o, req_loc_flit}),
      .out_stall_i({req_out_stall_i, 1'b0})
   );

   // Host never sends responses, local sink always ready
   noc_router #(
      .FLIT_W ($bits(noc_pkg::rsp_flit_t)),
      .X_COORD(0),
      .Y_COORD(0)
   ) i_rsp_router (
      .clk_i,
      .reset_i,
      .in_valid_i ({rsp_in_valid_i, 1'b0}),
      .in_flit_i  ({rsp_in_flit_i, noc_pkg::rsp_flit_t'('0)}),
      .in_stall_o ({rsp_in_stall_o, rsp_loc_stall}),
      .out_valid_o({rsp_out_valid_o, rsp_valid_o}),
      .out_flit_o ({rsp_out_flit_o, rsp_loc_flit}),
      .out_stall_i({rsp_out_stall_i, 1'b0})
   );

   a_tag_free : assert property (@(posedge clk_i) disable iff (reset_i)
      cmd_take |-> !tag_busy_q[cmd_tag_i])
      else $error("command tag %0d already outstanding", cmd_tag_i);

   a_tag_known : assert property (@(posedge clk_i) disable iff (reset_i)
      rsp_valid_o |-> tag_busy_q[rsp_tag_o])
      else $error("response for idle tag %0d", rsp_tag_o);

   // Only memory tiles are request targets
   a_host_sink : assert property (@(posedge clk_i) disable iff (reset_i)
      !req_loc_valid && !rsp_loc_stall)
      else $error("request %h delivered to host", req_loc_flit);

endmodule

/* logic/mem_tile.sv */
////////////////////
// Memory tile, 16 words behind a request and a response router
// Answers every request with a response flit to its source
////////////////////

`timescale 1ns/1ps

`include "noc_defines.svh"

module mem_tile #(
   parameter int X_COORD = 1,
   parameter int Y_COORD = 0
) (
   input  logic                     clk_i,
   input  logic                     reset_i,
   output logic [4:1]               req_out_valid_o,
   output noc_pkg::req_flit_t [4:1] req_out_flit_o,
   input  logic [4:1]               req_out_stall_i,
   input  logic [4:1]               req_in_valid_i,
   input  noc_pkg::req_flit_t [4:1] req_in_flit_i,
   output logic [4:1]               req_in_stall_o,
   output logic [4:1]               rsp_out_valid_o,
   output noc_pkg::rsp_flit_t [4:1] rsp_out_flit_o,
   input  logic [4:1]               rsp_out_stall_i,
   input  logic [4:1]               rsp_in_valid_i,
   input  noc_pkg::rsp_flit_t [4:1] rsp_in_flit_i,
   output logic [4:1]               rsp_in_stall_o
);

   logic                   req_loc_valid;
   noc_pkg::req_flit_t     req_loc_flit;
   logic                   req_loc_in_stall;
   logic                   rsp_free;
   logic                   req_take;
   logic                   rsp_valid_q;
   noc_pkg::rsp_flit_t     rsp_flit_q;
   logic                   rsp_loc_stall;
   logic                   rsp_loc_valid;
   noc_pkg::rsp_flit_t     rsp_loc_flit;
   logic [`NOC_DATA_W-1:0] mem_q [`NOC_MEM_WORDS];

   // Response register frees up as its flit leaves
   assign rsp_free = !rsp_valid_q || !rsp_loc_stall;
   assign req_take = req_loc_valid && rsp_free;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rsp_valid_q <= 1'b0;
         for (int w = 0; w < `NOC_MEM_WORDS; w++) begin
            mem_q[w] <= '0;
         end
      end else begin
         if (req_take) begin
            rsp_valid_q <= 1'b1;
            if (req_loc_flit.op == noc_pkg::MEM_WRITE) begin
               mem_q[req_loc_flit.addr] <= req_loc_flit.data;
            end
         end else if (!rsp_loc_stall) begin
            rsp_valid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (req_take) begin
         rsp_flit_q.dst <= req_loc_flit.src;
         rsp_flit_q.tag <= req_loc_flit.tag;
         // Writes answer with zero
         rsp_flit_q.data <= (req_loc_flit.op == noc_pkg::MEM_READ) ?
                            mem_q[req_loc_flit.addr] : '0;
      end
   end

   noc_router #(
      .FLIT_W ($bits(noc_pkg::req_flit_t)),
      .X_COORD(X_COORD),
      .Y_COORD(Y_COORD)
   ) i_req_router (
      .clk_i,
      .reset_i,
      .in_valid_i ({req_in_valid_i, 1'b0}),
      .in_flit_i  ({req_in_flit_i, noc_pkg::req_flit_t'('0)}),
      .in_stall_o ({req_in_stall_o, req_loc_in_stall}),
      .out_valid_o({req_out_valid_o, req_loc_valid}),
      .out_flit_o ({req_out_flit_o, req_loc_flit}),
      .out_stall_i({req_out_stall_i, !rsp_free})
   );

   noc_router #(
      .FLIT_W ($bits(noc_pkg::rsp_flit_t)),
      .X_COORD(X_COORD),
      .Y_COORD(Y_COORD)
   ) i_rsp_router (
      .clk_i,
      .reset_i,
      .in_valid_i ({rsp_in_valid_i, rsp_valid_q}),
      .in_flit_i  ({rsp_in_flit_i, rsp_flit_q}),
      .in_stall_o ({rsp_in_stall_o, rsp_loc_stall}),
      .out_valid_o({rsp_out_valid_o, rsp_loc_valid}),
      .out_flit_o ({rsp_out_flit_o, rsp_loc_flit}),
      .out_stall_i({rsp_out_stall_i, 1'b0})
   );

   a_rsp_hold : assert property (@(posedge clk_i) disable iff (reset_i)
      rsp_valid_q && rsp_loc_stall |=> rsp_valid_q && $stable(rsp_flit_q))
      else $error("tile (%0d,%0d) response overwritten", X_COORD, Y_COORD);

   // Responses only ever target the host
   a_mem_sink : assert property (@(posedge clk_i) disable iff (reset_i)
      !rsp_loc_valid && !req_loc_in_stall)
      else $error("tile (%0d,%0d) got response %h", X_COORD, Y_COORD, rsp_loc_flit);

endmodule

/* logic/mesh_top.sv */
////////////////////
// Two-by-two mesh, host tile at (0,0) and memory tiles elsewhere
// Links each port to the opposite port of its neighbor, edges tied off
////////////////////

`timescale 1ns/1ps

`include "noc_defines.svh"

module mesh_top (
   input  logic                              clk_i,
   input  logic                              reset_i,
   input  logic                              cmd_valid_i,
   input  noc_pkg::mem_op_e                  cmd_op_i,
   input  noc_pkg::coord_t                   cmd_tile_i,
   input  logic [$clog2(`NOC_MEM_WORDS)-1:0] cmd_addr_i,
   input  logic [`NOC_DATA_W-1:0]            cmd_data_i,
   input  logic [`NOC_TAG_W-1:0]             cmd_tag_i,
   output logic                              cmd_busy_o,
   output logic                              rsp_valid_o,
   output logic [`NOC_TAG_W-1:0]             rsp_tag_o,
   output logic [`NOC_DATA_W-1:0]            rsp_data_o
);

   // Direction index follows noc_pkg::route_dir_e, local port stays inside the tile
   logic [`NOC_MESH_X-1:0][`NOC_MESH_Y-1:0][4:1] req_out_valid, req_out_stall;
   logic [`NOC_MESH_X-1:0][`NOC_MESH_Y-1:0][4:1] req_in_valid, req_in_stall;
   logic [`NOC_MESH_X-1:0][`NOC_MESH_Y-1:0][4:1] rsp_out_valid, rsp_out_stall;
   logic [`NOC_MESH_X-1:0][`NOC_MESH_Y-1:0][4:1] rsp_in_valid, rsp_in_stall;
   noc_pkg::req_flit_t [`NOC_MESH_X-1:0][`NOC_MESH_Y-1:0][4:1] req_out_flit, req_in_flit;
   noc_pkg::rsp_flit_t [`NOC_MESH_X-1:0][`NOC_MESH_Y-1:0][4:1] rsp_out_flit, rsp_in_flit;

   for (genvar x = 0; x < `NOC_MESH_X; x++) begin : gen_x
      for (genvar y = 0; y < `NOC_MESH_Y; y++) begin : gen_y

         ////////////////////
         // Tiles
         ////////////////////

         if (x == 0 && y == 0) begin : gen_host
            host_tile i_host_tile (
               .clk_i,
               .reset_i,
               .cmd_valid_i,
               .cmd_op_i,
               .cmd_tile_i,
               .cmd_addr_i,
               .cmd_data_i,
               .cmd_tag_i,
               .cmd_busy_o,
               .rsp_valid_o,
               .rsp_tag_o,
               .rsp_data_o,
               .req_out_valid_o(req_out_valid[x][y]),
               .req_out_flit_o (req_out_flit[x][y]),
               .req_out_stall_i(req_out_stall[x][y]),
               .req_in_valid_i (req_in_valid[x][y]),
               .req_in_flit_i  (req_in_flit[x][y]),
               .req_in_stall_o (req_in_stall[x][y]),
               .rsp_out_valid_o(rsp_out_valid[x][y]),
               .rsp_out_flit_o (rsp_out_flit[x][y]),
               .rsp_out_stall_i(rsp_out_stall[x][y]),
               .rsp_in_valid_i (rsp_in_valid[x][y]),
               .rsp_in_flit_i  (rsp_in_flit[x][y]),
               .rsp_in_stall_o (rsp_in_stall[x][y])
            );
         end else begin : gen_mem
            mem_tile #(
               .X_COORD(x),
               .Y_COORD(y)
            ) i_mem_tile (
               .clk_i,
               .reset_i,
               .req_out_valid_o(req_out_valid[x][y]),
               .req_out_flit_o (req_out_flit[x][y]),
               .req_out_stall_i(req_out_stall[x][y]),
               .req_in_valid_i (req_in_valid[x][y]),
               .req_in_flit_i  (req_in_flit[x][y]),
               .req_in_stall_o (req_in_stall[x][y]),
               .rsp_out_valid_o(rsp_out_valid[x][y]),
               .rsp_out_flit_o (rsp_out_flit[x][y]),
               .rsp_out_stall_i(rsp_out_stall[x][y]),
               .rsp_in_valid_i (rsp_in_valid[x][y]),
               .rsp_in_flit_i  (rsp_in_flit[x][y]),
               .rsp_in_stall_o (rsp_in_stall[x][y])
            );
         end

         ////////////////////
         // Mesh links
         ////////////////////

         for (genvar d = 1; d <= 4; d++) begin : gen_dir
            localparam int Nx = (d == int'(noc_pkg::DIR_EAST)) ? x + 1 :
                                (d == int'(noc_pkg::DIR_WEST)) ? x - 1 : x;
            localparam int Ny = (d == int'(noc_pkg::DIR_NORTH)) ? y + 1 :
                                (d == int'(noc_pkg::DIR_SOUTH)) ? y - 1 : y;
            // North pairs with south, east with west
            localparam int Od = (d + 1) % 4 + 1;

            if (Nx < 0 || Nx >= `NOC_MESH_X || Ny < 0 || Ny >= `NOC_MESH_Y) begin : gen_tie
               assign req_in_valid[x][y][d]  = 1'b0;
               assign req_in_flit[x][y][d]   = '0;
               assign req_out_stall[x][y][d] = 1'b0;
               assign rsp_in_valid[x][y][d]  = 1'b0;
               assign rsp_in_flit[x][y][d]   = '0;
               assign rsp_out_stall[x][y][d] = 1'b0;
            end else begin : gen_link
               assign req_in_valid[x][y][d]  = req_out_valid[Nx][Ny][Od];
               assign req_in_flit[x][y][d]   = req_out_flit[Nx][Ny][Od];
               assign req_out_stall[x][y][d] = req_in_stall[Nx][Ny][Od];
               assign rsp_in_valid[x][y][d]  = rsp_out_valid[Nx][Ny][Od];
               assign rsp_in_flit[x][y][d]   = rsp_out_flit[Nx][Ny][Od];
               assign rsp_out_stall[x][y][d] = rsp_in_stall[Nx][Ny][Od];
            end
         end
      end
   end

endmodule

/* tb/tb_mesh_top.sv */
////////////////////
// Testbench for the mesh, driven from the golden command file tb/mesh_golden.txt
// Drives the command port and matches each response to its command by tag
////////////////////

`timescale 1ns/1ps

`include "noc_defines.svh"

module tb_mesh_top;

   localparam int NumTags = 1 << `NOC_TAG_W;
   localparam int AddrW   = $clog2(`NOC_MEM_WORDS);

   logic                   clk_i;
   logic                   reset_i;
   logic                   cmd_valid_i;
   noc_pkg::mem_op_e       cmd_op_i;
   noc_pkg::coord_t        cmd_tile_i;
   logic [AddrW-1:0]       cmd_addr_i;
   logic [`NOC_DATA_W-1:0] cmd_data_i;
   logic [`NOC_TAG_W-1:0]  cmd_tag_i;
   logic                   cmd_busy_o;
   logic                   rsp_valid_o;
   logic [`NOC_TAG_W-1:0]  rsp_tag_o;
   logic [`NOC_DATA_W-1:0] rsp_data_o;

   // Golden commands
   noc_pkg::mem_op_e       gold_op   [$];
   noc_pkg::coord_t        gold_tile [$];
   logic [AddrW-1:0]       gold_addr [$];
   logic [`NOC_DATA_W-1:0] gold_data [$];
   logic [`NOC_TAG_W-1:0]  gold_tag  [$];
   logic [`NOC_DATA_W-1:0] gold_exp  [$];
   int                     cmd_total;

   // Commands in flight
   logic [NumTags-1:0]     pending;
   logic [`NOC_DATA_W-1:0] expect_data [NumTags];
   noc_pkg::coord_t        tile_of     [NumTags];
   noc_pkg::coord_t        order_tile  [$];
   logic [`NOC_TAG_W-1:0]  order_tag   [$];
   int                     answered;
   logic                   full_seen;

   int cycle_count = 0;
   int cycle_limit = 0;
   int seed;

   mesh_top i_mesh_top (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .cmd_valid_i(cmd_valid_i),
      .cmd_op_i   (cmd_op_i),
      .cmd_tile_i (cmd_tile_i),
      .cmd_addr_i (cmd_addr_i),
      .cmd_data_i (cmd_data_i),
      .cmd_tag_i  (cmd_tag_i),
      .cmd_busy_o (cmd_busy_o),
      .rsp_valid_o(rsp_valid_o),
      .rsp_tag_o  (rsp_tag_o),
      .rsp_data_o (rsp_data_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("TEST FAIL");
      $fatal(1, "simulation stopped at %0t", $time);
   endtask

   task automatic check_data(input string name, input logic [`NOC_DATA_W-1:0] got,
                             input logic [`NOC_DATA_W-1:0] exp);
      if (got !== exp) begin
         report_failure($sformatf("mismatch %s got %h expected %h", name, got, exp));
      end
   endtask

   task automatic check_tag(input string name, input logic [`NOC_TAG_W-1:0] got,
                            input logic [`NOC_TAG_W-1:0] exp);
      if (got !== exp) begin
         report_failure($sformatf("mismatch %s got %h expected %h", name, got, exp));
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         report_failure($sformatf("mismatch %s got %h expected %h", name, got, exp));
      end
   endtask

   task automatic load_golden();
      int          fd;
      int          n;
      int          f_op;
      int          f_tile;
      int          f_addr;
      int          f_tag;
      logic [31:0] f_data;
      logic [31:0] f_exp;
      string       line;
      fd = $fopen("tb/mesh_golden.txt", "r");
      if (fd == 0) begin
         report_failure("could not open the golden file tb/mesh_golden.txt");
      end else begin
         while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%h %h %h %h %h %h", f_op, f_tile, f_addr, f_data, f_tag, f_exp);
            if (line.getc(0) == "#" || n <= 0) begin
               n = 0;
            end else if (n != 6) begin
               report_failure($sformatf("golden line is malformed: %s", line));
            end else if (f_tile < 1 || f_tile > 3) begin
               report_failure($sformatf("golden line does not target a memory tile: %s", line));
            end else begin
               gold_op.push_back(noc_pkg::mem_op_e'(f_op[0]));
               gold_tile.push_back(noc_pkg::coord_t'(f_tile[1:0]));
               gold_addr.push_back(f_addr[AddrW-1:0]);
               gold_data.push_back(f_data);
               gold_tag.push_back(f_tag[`NOC_TAG_W-1:0]);
               gold_exp.push_back(f_exp);
            end
         end
         $fclose(fd);
      end
   endtask

   // Holds the command until the host takes it
   task automatic send_command(input int i);
      cmd_valid_i <= 1'b1;
      cmd_op_i    <= gold_op[i];
      cmd_tile_i  <= gold_tile[i];
      cmd_addr_i  <= gold_addr[i];
      cmd_data_i  <= gold_data[i];
      cmd_tag_i   <= gold_tag[i];
      @(negedge clk_i);
      while (cmd_busy_o) begin
         @(negedge clk_i);
      end
      @(posedge clk_i);
      pending[gold_tag[i]]     = 1'b1;
      expect_data[gold_tag[i]] = gold_exp[i];
      tile_of[gold_tag[i]]     = gold_tile[i];
      order_tile.push_back(gold_tile[i]);
      order_tag.push_back(gold_tag[i]);
   endtask

   ////////////////////
   // Response monitor
   ////////////////////

   always @(negedge clk_i) begin
      int pos;
      if (!reset_i) begin
         // All tags in use
         if ($countones(pending) == NumTags) begin
            full_seen = 1'b1;
            check_flag("cmd_busy_o", cmd_busy_o, 1'b1);
         end
         if (rsp_valid_o) begin
            if (!pending[rsp_tag_o]) begin
               report_failure($sformatf("response arrived with tag %0d %s", rsp_tag_o,
                                        "while no command with that tag is outstanding"));
            end else begin
               // One tile answers in the order it was asked
               pos = -1;
               for (int k = 0; k < order_tag.size(); k++) begin
                  if (pos < 0 && order_tile[k] == tile_of[rsp_tag_o]) begin
                     pos = k;
                  end
               end
               check_tag("rsp_tag_o", rsp_tag_o, order_tag[pos]);
               check_data("rsp_data_o", rsp_data_o, expect_data[rsp_tag_o]);
               order_tile.delete(pos);
               order_tag.delete(pos);
               pending[rsp_tag_o] = 1'b0;
               answered = answered + 1;
            end
         end
      end
   end

   always @(posedge clk_i) begin
      cycle_count = cycle_count + 1;
      if (cycle_limit > 0 && cycle_count > cycle_limit) begin
         report_failure($sformatf("timeout after %0d cycles with %0d of %0d commands answered",
                                  cycle_count, answered, cmd_total));
      end
   end

   ////////////////////
   // Stimulus
   ////////////////////

   initial begin
      int idle;
      seed        = 53;
      pending     = '0;
      answered    = 0;
      full_seen   = 1'b0;
      reset_i     = 1'b1;
      cmd_valid_i = 1'b0;
      cmd_op_i    = noc_pkg::MEM_READ;
      cmd_tile_i  = '0;
      cmd_addr_i  = '0;
      cmd_data_i  = '0;
      cmd_tag_i   = '0;
      load_golden();
      cmd_total   = gold_tag.size();
      cycle_limit = cmd_total * 40 + 200;

      repeat (5) @(posedge clk_i);
      reset_i <= 1'b0;
      @(negedge clk_i);
      check_flag("rsp_valid_o", rsp_valid_o, 1'b0);
      check_flag("cmd_busy_o", cmd_busy_o, 1'b0);
      @(posedge clk_i);

      for (int i = 0; i < cmd_total; i++) begin
         // Each round of tags starts on a drained mesh
         if (gold_tag[i] == '0) begin
            cmd_valid_i <= 1'b0;
            while (pending != '0) begin
               @(posedge clk_i);
            end
            idle = $unsigned($random(seed)) % 4;
            repeat (idle) @(posedge clk_i);
         end
         while (pending[gold_tag[i]]) begin
            cmd_valid_i <= 1'b0;
            @(posedge clk_i);
         end
         send_command(i);
      end
      cmd_valid_i <= 1'b0;

      while (pending != '0 || answered < cmd_total) begin
         @(posedge clk_i);
      end
      // Room for a stray duplicate response
      repeat (20) @(posedge clk_i);

      // Every tag is free again
      @(negedge clk_i);
      check_flag("cmd_busy_o", cmd_busy_o, 1'b0);

      if (!full_seen) begin
         report_failure("the run never had all tags outstanding at the same time");
      end else begin
         $display("TEST PASS");
         $finish;
      end
   end

endmodule

/* tb/mesh_golden.txt */
# op tile addr data tag expect, all hex; op 0 is read and 1 is write
# tile holds {x,y}: 1 is (0,1), 2 is (1,0), 3 is (1,1); expect is the response data

# Reads after reset, then writes of one address in each tile
0 2 5 00000000 0 00000000
0 1 f 00000000 1 00000000
0 3 0 00000000 2 00000000
1 2 3 11111111 3 00000000
1 1 3 22222222 4 00000000
1 3 3 33333333 5 00000000
0 2 3 00000000 6 11111111
0 3 3 00000000 7 33333333

# Far and near tiles back to back
0 3 3 00000000 0 33333333
0 2 3 00000000 1 11111111
0 1 3 00000000 2 22222222
1 3 9 deadbeef 3 00000000
1 1 9 cafef00d 4 00000000
0 3 9 00000000 5 deadbeef
0 1 9 00000000 6 cafef00d
0 2 9 00000000 7 00000000

# Burst to the far tile fills all tags
1 3 1 a5a5a5a5 0 00000000
1 3 2 5a5a5a5a 1 00000000
0 3 1 00000000 2 a5a5a5a5
0 3 2 00000000 3 5a5a5a5a
0 3 3 00000000 4 33333333
0 3 9 00000000 5 deadbeef
1 3 3 0badc0de 6 00000000
0 3 3 00000000 7 0badc0de

/* tb.f */
+incdir+logic
logic/noc_pkg.sv
logic/noc_router.sv
logic/host_tile.sv
logic/mem_tile.sv
logic/mesh_top.sv
tb/tb_mesh_top.sv

/* Makefile */
# Verilator build and run for the mesh testbench

VERILATOR  ?= verilator
TOP        := tb_mesh_top
FILELIST   := tb.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
